// ==== bench/tb_rv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ctrl;

	import rv_ctrl_pkg::*;

	localparam int N_DIRECTED = 56;
	localparam int N_RANDOM   = 200;

	logic clk;
	logic rst;
	xlen_t instr;
	xlen_t rs1_data;
	xlen_t rs2_data;

	alu_op_t alu_op;
	mul_op_t mul_op;
	res_sel_t res_sel;
	fwd_sel_t fwd1_sel;
	fwd_sel_t fwd2_sel;
	logic src1_pc;
	logic src2_imm;
	load_kind_t load_kind;
	store_kind_t store_kind;
	logic dm_web;
	logic wb_en;
	pc_sel_t pc_sel;
	instr_sel_t instr_sel;

	integer seed = 62259;
	integer errors = 0;
	integer tests = 0;
	string test_name = "reset";

	rv_ctrl_top i_dut (
		.clk(clk), .rst(rst), .instr(instr), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.alu_op(alu_op), .mul_op(mul_op), .res_sel(res_sel), .fwd1_sel(fwd1_sel),
		.fwd2_sel(fwd2_sel), .src1_pc(src1_pc), .src2_imm(src2_imm), .load_kind(load_kind),
		.store_kind(store_kind), .dm_web(dm_web), .wb_en(wb_en), .pc_sel(pc_sel),
		.instr_sel(instr_sel)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reference model state, one copy per pipeline stage
	reg_addr_t m_rd_ex, m_rd_mem, m_rd_wb;
	logic m_en_ex, m_en_mem, m_en_wb;
	opcode_t m_op_ex;
	logic m_taken, m_lu_q, m_web;
	alu_op_t m_alu;
	mul_op_t m_mul;
	res_sel_t m_res;
	fwd_sel_t m_f1, m_f2;
	logic m_pc1, m_imm2;
	load_kind_t m_ld;
	store_kind_t m_st;

	opcode_t id_op;
	funct3_t id_f3;
	funct7_t id_f7;
	reg_addr_t id_rs1, id_rs2;
	logic m_load_use, m_redirect;
	pc_sel_t m_pc_sel;
	instr_sel_t m_instr_sel;

	assign id_op  = instr[6:0];
	assign id_f3  = instr[14:12];
	assign id_f7  = instr[31:25];
	assign id_rs1 = instr[19:15];
	assign id_rs2 = instr[24:20];

	assign m_load_use = m_op_ex == OP_LOAD && m_rd_ex != 5'd0
		&& (m_rd_ex == id_rs1 || m_rd_ex == id_rs2);
	assign m_redirect = m_op_ex == OP_JAL || m_op_ex == OP_JALR
		|| (m_op_ex == OP_BRANCH && m_taken);
	assign m_pc_sel = m_redirect ? PC_TARGET : (m_load_use ? PC_HOLD : PC_NEXT);
	assign m_instr_sel = m_redirect ? INS_NOP : (m_lu_q ? INS_REPEAT : INS_FETCH);

	function automatic logic branch_cond(input funct3_t f3, input xlen_t a, input xlen_t b);
		case (f3)
			3'b000: return a == b;   // BEQ
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;   // BGEU
			default: return 1'b0;
		endcase
	endfunction

	function automatic fwd_sel_t nearest(input reg_addr_t src);
		if (src != 5'd0 && m_en_ex && src == m_rd_ex)
			return FWD_EX;
		if (src != 5'd0 && m_en_mem && src == m_rd_mem)
			return FWD_MEM;
		if (src != 5'd0 && m_en_wb && src == m_rd_wb)
			return FWD_WB;
		return FWD_REG;
	endfunction

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			m_en_ex <= 1'b0;
			m_en_mem <= 1'b0;
			m_en_wb <= 1'b0;
			m_op_ex <= '0;
			m_taken <= 1'b0;
			m_lu_q <= 1'b0;
			m_web <= 1'b1;
			m_alu <= '0;
			m_mul <= '0;
			m_res <= RES_ALU;
			m_f1 <= FWD_REG;
			m_f2 <= FWD_REG;
			m_pc1 <= 1'b0;
			m_imm2 <= 1'b0;
			m_ld <= LD_NONE;
			m_st <= ST_NONE;
		end else begin
			m_rd_ex  <= instr[11:7];
			m_rd_mem <= m_rd_ex;
			m_rd_wb  <= m_rd_mem;
			m_en_ex  <= !(id_op == OP_BRANCH || id_op == OP_STORE || m_redirect || m_load_use);
			m_en_mem <= m_en_ex;
			m_en_wb  <= m_en_mem;
			m_op_ex  <= m_load_use ? 7'd0 : id_op;   // Bubble on a stall
			m_lu_q   <= m_load_use;
			if (id_op == OP_BRANCH)
				m_taken <= branch_cond(id_f3, rs1_data, rs2_data);
			m_f1 <= nearest(id_rs1);
			m_f2 <= nearest(id_rs2);
			if (id_op == OP_RTYPE || (id_op == OP_ITYPE && id_f3[1:0] == 2'b01))
				m_alu <= {id_f7[5], id_f3};
			else if (id_op == OP_ITYPE)
				m_alu <= {1'b0, id_f3};
			else
				m_alu <= (id_op == OP_LUI) ? 4'b1001 : 4'b0000;
			if (id_op == OP_RTYPE && id_f7[0])
				m_mul <= id_f3[1:0];
			if (id_op == OP_RTYPE && id_f7[0])
				m_res <= RES_MUL;
			else
				m_res <= (id_op == OP_JAL || id_op == OP_JALR) ? RES_LINK : RES_ALU;
			m_pc1  <= id_op == OP_BRANCH || id_op == OP_AUIPC || id_op == OP_JAL;
			m_imm2 <= id_op != OP_RTYPE;
			m_web  <= !(id_op == OP_STORE && !m_load_use);
			m_ld <= LD_NONE;
			m_st <= ST_NONE;
			if (id_op == OP_LOAD)
				m_ld <= id_f3 == 3'd0 ? LD_B : id_f3 == 3'd1 ? LD_H : id_f3 == 3'd2 ? LD_W
					: id_f3 == 3'd4 ? LD_BU : id_f3 == 3'd5 ? LD_HU : LD_NONE;
			if (id_op == OP_STORE)
				m_st <= id_f3 == 3'd0 ? ST_B : id_f3 == 3'd1 ? ST_H
					: id_f3 == 3'd2 ? ST_W : ST_NONE;
		end
	end

	task automatic report(input string sig, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("[FAIL] %s %s expected %0h actual %0h", test_name, sig, exp, act);
	endtask

	a_wb: assert property (@(posedge clk) disable iff (rst) wb_en == m_en_ex)
		else report("wb_en", 32'($sampled(m_en_ex)), 32'($sampled(wb_en)));
	a_web: assert property (@(posedge clk) disable iff (rst) dm_web == m_web)
		else report("dm_web", 32'($sampled(m_web)), 32'($sampled(dm_web)));
	a_alu: assert property (@(posedge clk) disable iff (rst) alu_op == m_alu)
		else report("alu_op", 32'($sampled(m_alu)), 32'($sampled(alu_op)));
	a_mul: assert property (@(posedge clk) disable iff (rst) mul_op == m_mul)
		else report("mul_op", 32'($sampled(m_mul)), 32'($sampled(mul_op)));
	a_res: assert property (@(posedge clk) disable iff (rst) res_sel == m_res)
		else report("res_sel", 32'($sampled(m_res)), 32'($sampled(res_sel)));
	a_src: assert property (@(posedge clk) disable iff (rst)
		src1_pc == m_pc1 && src2_imm == m_imm2)
		else report("src1_pc/src2_imm", 32'({$sampled(m_pc1), $sampled(m_imm2)}),
			32'({$sampled(src1_pc), $sampled(src2_imm)}));
	a_mem: assert property (@(posedge clk) disable iff (rst)
		load_kind == m_ld && store_kind == m_st)
		else report("load/store kind", 32'({$sampled(m_ld), $sampled(m_st)}),
			32'({$sampled(load_kind), $sampled(store_kind)}));
	a_fwd: assert property (@(posedge clk) disable iff (rst) fwd1_sel == m_f1 && fwd2_sel == m_f2)
		else report("fwd1/fwd2", 32'({$sampled(m_f1), $sampled(m_f2)}),
			32'({$sampled(fwd1_sel), $sampled(fwd2_sel)}));
	a_pc: assert property (@(posedge clk) disable iff (rst) pc_sel == m_pc_sel)
		else report("pc_sel", 32'($sampled(m_pc_sel)), 32'($sampled(pc_sel)));
	a_ins: assert property (@(posedge clk) disable iff (rst) instr_sel == m_instr_sel)
		else report("instr_sel", 32'($sampled(m_instr_sel)), 32'($sampled(instr_sel)));

	function automatic xlen_t enc(input funct7_t f7, input reg_addr_t r2, input reg_addr_t r1,
		input funct3_t f3, input reg_addr_t rd, input opcode_t op);
		return {f7, r2, r1, f3, rd, op};
	endfunction

	task automatic issue(input xlen_t word, input xlen_t a, input xlen_t b);
		@(negedge clk);
		instr    = word;
		rs1_data = a;
		rs2_data = b;
	endtask

	task automatic finish_test;
		repeat (2) @(negedge clk);   // Last instruction's EX controls get checked
		tests++;
		$display("test %s done, %0d errors so far", test_name, errors);
	endtask

	// Hard stop sized from the instruction count
	initial begin
		#((N_DIRECTED + N_RANDOM + 20) * 20);
		$display("Watchdog expired before the stimulus completed");
		$display("Verification failed");
		$finish;
	end

	opcode_t legal_ops [9] = '{OP_RTYPE, OP_ITYPE, OP_LOAD, OP_STORE, OP_BRANCH,
		OP_JAL, OP_JALR, OP_LUI, OP_AUIPC};
	funct3_t br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	initial begin
		funct7_t f7;
		rst = 1'b1;
		instr = '0;
		rs1_data = '0;
		rs2_data = '0;
		repeat (2) @(negedge clk);
		a_reset: assert (wb_en === 1'b0 && dm_web === 1'b1 && pc_sel === PC_NEXT
			&& instr_sel === INS_FETCH)
			else report("reset values", 32'({1'b0, 1'b1, PC_NEXT, INS_FETCH}),
				32'({wb_en, dm_web, pc_sel, instr_sel}));
		rst = 1'b0;
		finish_test();

		test_name = "decode";
		issue(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OP_RTYPE), 0, 0);   // ADD
		issue(enc(7'h20, 5'd2, 5'd1, 3'd0, 5'd4, OP_RTYPE), 0, 0);   // SUB
		for (int k = 0; k < 4; k++)
			issue(enc(7'h01, 5'd2, 5'd1, 3'(k), 5'd9, OP_RTYPE), 0, 0);
		issue(enc(7'h00, 5'd3, 5'd1, 3'd1, 5'd5, OP_ITYPE), 0, 0);   // SLLI
		issue(enc(7'h20, 5'd3, 5'd1, 3'd5, 5'd5, OP_ITYPE), 0, 0);   // SRAI
		issue(enc(7'h7f, 5'd31, 5'd1, 3'd0, 5'd6, OP_ITYPE), 0, 0);
		issue(enc(7'h12, 5'd3, 5'd4, 3'd2, 5'd7, OP_LUI), 0, 0);
		issue(enc(7'h12, 5'd3, 5'd4, 3'd2, 5'd8, OP_AUIPC), 0, 0);
		issue(enc(7'h00, 5'd8, 5'd0, 3'd0, 5'd1, OP_JAL), 0, 0);
		issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd2, OP_ITYPE), 0, 0);   // Flushed slot
		issue(enc(7'h00, 5'd0, 5'd1, 3'd0, 5'd1, OP_JALR), 0, 0);
		issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd2, OP_ITYPE), 0, 0);
		finish_test();

		test_name = "memory";
		for (int k = 0; k < 6; k++)
			if (k != 3)
				issue(enc(7'h00, 5'd0, 5'd1, 3'(k), 5'(10 + k), OP_LOAD), 0, 0);
		for (int k = 0; k < 3; k++)
			issue(enc(7'h00, 5'd2, 5'd1, 3'(k), 5'd0, OP_STORE), 0, 0);
		issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OP_ITYPE), 0, 0);
		finish_test();

		test_name = "forward";
		issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd5, OP_ITYPE), 0, 0);
		issue(enc(7'h00, 5'd5, 5'd0, 3'd0, 5'd6, OP_RTYPE), 0, 0);   // x5 from EX
		issue(enc(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, OP_RTYPE), 0, 0);
		issue(enc(7'h00, 5'd6, 5'd5, 3'd0, 5'd0, OP_RTYPE), 0, 0);
		issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OP_STORE), 0, 0);
		finish_test();

		test_name = "load_use";
		issue(enc(7'h00, 5'd0, 5'd1, 3'd2, 5'd7, OP_LOAD), 0, 0);
		issue(enc(7'h00, 5'd7, 5'd1, 3'd2, 5'd0, OP_STORE), 0, 0);   // Stalled store
		issue(enc(7'h00, 5'd7, 5'd1, 3'd0, 5'd8, OP_RTYPE), 0, 0);
		finish_test();

		test_name = "branch";
		for (int k = 0; k < 12; k++) begin
			issue(enc(7'h00, 5'd2, 5'd1, br_f3[3'(k / 2)], 5'd0, OP_BRANCH),
				(k % 2 && k < 8) ? 32'hffff_fff0 : 32'd5,
				(k % 2 && k >= 8) ? 32'hffff_fff0 : 32'd5);
			issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd3, OP_ITYPE), 0, 0);
		end
		finish_test();

		test_name = "random";
		for (int n = 0; n < N_RANDOM; n++) begin
			case ($unsigned($random(seed)) % 3)
				0: f7 = 7'h00;
				1: f7 = 7'h20;
				default: f7 = 7'h01;
			endcase
			issue(enc(f7, 5'($unsigned($random(seed)) % 8), 5'($unsigned($random(seed)) % 8),
				3'($random(seed)), 5'($unsigned($random(seed)) % 8),
				legal_ops[4'($unsigned($random(seed)) % 9)]),
				$random(seed) & 32'h8000_000f, $random(seed) & 32'h8000_000f);
		end
		finish_test();

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_ctrl_pkg::opcode_t  opcode,
	input  rv_ctrl_pkg::funct3_t  funct3,
	input  rv_ctrl_pkg::xlen_t    rs1_data,
	input  rv_ctrl_pkg::xlen_t    rs2_data,
	output logic                  taken
);

	import rv_ctrl_pkg::*;

	logic cond;

	always_comb begin
		case (funct3[2:1])
			2'b00:   cond = (rs1_data == rs2_data) ^ funct3[0];   // BEQ, BNE
			2'b10:   cond = ($signed(rs1_data) < $signed(rs2_data)) ^ funct3[0];   // BLT, BGE
			2'b11:   cond = (rs1_data < rs2_data) ^ funct3[0];   // BLTU, BGEU
			default: cond = 1'b0;
		endcase
	end

	// Only a branch updates the flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			taken <= 1'b0;
		else if (opcode == OP_BRANCH)
			taken <= cond;
	end

endmodule

`default_nettype wire

// ==== rtl/dest_track.sv ====
`timescale 1ns/1ps
`default_nettype none

module dest_track (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_ctrl_pkg::opcode_t  opcode,
	input  rv_ctrl_pkg::reg_addr_t rd,
	input  logic                  load_use,
	input  logic                  flush,
	output logic                  wb_en,
	output rv_ctrl_pkg::reg_addr_t rd_ex,
	output rv_ctrl_pkg::reg_addr_t rd_mem,
	output rv_ctrl_pkg::reg_addr_t rd_wb,
	output logic                  wb_en_mem,
	output logic                  wb_en_wb
);

	import rv_ctrl_pkg::*;

	logic wb_en_id;

	// Branch and store never write a register; bubbles and flushed slots neither
	assign wb_en_id = !(opcode == OP_BRANCH || opcode == OP_STORE || flush || load_use);

	// Destination index follows its instruction from EX to WB
	always_ff @(posedge clk) begin
		rd_ex  <= rd;
		rd_mem <= rd_ex;
		rd_wb  <= rd_mem;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_en     <= 1'b0;
			wb_en_mem <= 1'b0;
			wb_en_wb  <= 1'b0;
		end else begin
			wb_en     <= wb_en_id;   // EX copy
			wb_en_mem <= wb_en;
			wb_en_wb  <= wb_en_mem;
		end
	end

	// A branch seen in ID must reach MEM with its write enable cleared
	a_branch_no_wb_mem: assert property (
		@(posedge clk) disable iff (rst)
		$past(opcode == OP_BRANCH, 2) |-> !wb_en_mem
	) else $error("dest_track: write enable reached MEM for a branch");

endmodule

`default_nettype wire

// ==== rtl/hazard_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  rv_ctrl_pkg::opcode_t    opcode,
	input  rv_ctrl_pkg::reg_addr_t  rs1,
	input  rv_ctrl_pkg::reg_addr_t  rs2,
	input  rv_ctrl_pkg::reg_addr_t  rd_ex,
	input  rv_ctrl_pkg::reg_addr_t  rd_mem,
	input  rv_ctrl_pkg::reg_addr_t  rd_wb,
	input  logic                    wb_en,
	input  logic                    wb_en_mem,
	input  logic                    wb_en_wb,
	output rv_ctrl_pkg::fwd_sel_t   fwd1_sel,
	output rv_ctrl_pkg::fwd_sel_t   fwd2_sel,
	output rv_ctrl_pkg::opcode_t    opcode_ex,
	output logic                    load_use,
	output logic                    load_use_q
);

	import rv_ctrl_pkg::*;

	// Nearest producer wins
	function automatic fwd_sel_t pick_src(input reg_addr_t src);
		fwd_sel_t sel;
		if (src == rd_ex && rd_ex != '0 && wb_en)
			sel = FWD_EX;
		else if (src == rd_mem && rd_mem != '0 && wb_en_mem)
			sel = FWD_MEM;
		else if (src == rd_wb && rd_wb != '0 && wb_en_wb)
			sel = FWD_WB;
		else
			sel = FWD_REG;
		return sel;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fwd1_sel <= FWD_REG;
			fwd2_sel <= FWD_REG;
		end else begin
			fwd1_sel <= pick_src(rs1);
			fwd2_sel <= pick_src(rs2);
		end
	end

	// Load in EX feeding the instruction in ID
	assign load_use = (opcode_ex == OP_LOAD) && (rd_ex != '0)
		&& ((rd_ex == rs1) || (rd_ex == rs2));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			opcode_ex  <= '0;
			load_use_q <= 1'b0;
		end else begin
			opcode_ex  <= load_use ? '0 : opcode;   // Bubble into EX
			load_use_q <= load_use;
		end
	end

	// The bubble clears opcode_ex, so a stall never repeats
	a_no_double_stall: assert property (
		@(posedge clk) disable iff (rst)
		load_use |=> !load_use
	) else $error("hazard_ctrl: load-use held for two cycles");

endmodule

`default_nettype wire

// ==== rtl/op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_decode (
	input  logic                      clk,
	input  logic                      rst,
	input  rv_ctrl_pkg::opcode_t      opcode,
	input  rv_ctrl_pkg::funct3_t      funct3,
	input  rv_ctrl_pkg::funct7_t      funct7,
	input  logic                      load_use,
	output rv_ctrl_pkg::alu_op_t      alu_op,
	output rv_ctrl_pkg::mul_op_t      mul_op,
	output rv_ctrl_pkg::res_sel_t     res_sel,
	output logic                      src1_pc,
	output logic                      src2_imm,
	output rv_ctrl_pkg::load_kind_t   load_kind,
	output rv_ctrl_pkg::store_kind_t  store_kind,
	output logic                      dm_web
);

	import rv_ctrl_pkg::*;

	logic is_mext;
	logic is_shift;

	assign is_mext  = (opcode == OP_RTYPE) && funct7[0];
	assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);   // SLLI, SRLI, SRAI

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op   <= '0;
			res_sel  <= RES_ALU;
			src1_pc  <= 1'b0;
			src2_imm <= 1'b0;
			dm_web   <= 1'b1;   // Read
		end else begin
			case (opcode)
				OP_RTYPE: alu_op <= {funct7[5], funct3};
				OP_ITYPE: alu_op <= is_shift ? {funct7[5], funct3} : {1'b0, funct3};
				OP_LUI:   alu_op <= ALU_PASS_LUI;
				default:  alu_op <= '0;
			endcase

			if (is_mext)
				res_sel <= RES_MUL;
			else if (opcode == OP_JAL || opcode == OP_JALR)
				res_sel <= RES_LINK;   // rd gets pc + 4
			else
				res_sel <= RES_ALU;

			src1_pc  <= (opcode == OP_BRANCH) || (opcode == OP_AUIPC) || (opcode == OP_JAL);
			src2_imm <= (opcode != OP_RTYPE);
			dm_web   <= !((opcode == OP_STORE) && !load_use);
		end
	end

	// Holds its last value outside M-extension ops
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mul_op <= MUL_MUL;
		end else if (is_mext) begin
			case (funct3[1:0])
				2'b00:   mul_op <= MUL_MUL;
				2'b01:   mul_op <= MUL_MULH;
				2'b10:   mul_op <= MUL_MULHSU;
				default: mul_op <= MUL_MULHU;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			load_kind  <= LD_NONE;
			store_kind <= ST_NONE;
		end else begin
			load_kind  <= LD_NONE;
			store_kind <= ST_NONE;
			if (opcode == OP_LOAD) begin
				case (funct3)
					3'b000:  load_kind <= LD_B;
					3'b001:  load_kind <= LD_H;
					3'b010:  load_kind <= LD_W;
					3'b100:  load_kind <= LD_BU;
					3'b101:  load_kind <= LD_HU;
					default: load_kind <= LD_NONE;
				endcase
			end
			if (opcode == OP_STORE) begin
				case (funct3)
					3'b010:  store_kind <= ST_W;
					3'b001:  store_kind <= ST_H;
					3'b000:  store_kind <= ST_B;
					default: store_kind <= ST_NONE;
				endcase
			end
		end
	end

	a_ld_st_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!((load_kind != LD_NONE) && (store_kind != ST_NONE))
	) else $error("op_decode: load and store active together");

endmodule

`default_nettype wire

// ==== rtl/redirect_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl (
	input  rv_ctrl_pkg::opcode_t     opcode_ex,
	input  logic                     taken,
	input  logic                     load_use,
	input  logic                     load_use_q,
	output rv_ctrl_pkg::pc_sel_t     pc_sel,
	output rv_ctrl_pkg::instr_sel_t  instr_sel,
	output logic                     flush
);

	import rv_ctrl_pkg::*;

	always_comb begin
		case (opcode_ex)
			OP_JAL, OP_JALR: pc_sel = PC_TARGET;
			OP_BRANCH:       pc_sel = taken ? PC_TARGET : PC_NEXT;
			default:         pc_sel = load_use ? PC_HOLD : PC_NEXT;
		endcase
	end

	assign flush = (pc_sel == PC_TARGET);

	always_comb begin
		if (flush)
			instr_sel = INS_NOP;   // Drop the wrong-path fetch
		else if (load_use_q)
			instr_sel = INS_REPEAT;   // Reissue the stalled instruction
		else
			instr_sel = INS_FETCH;
	end

	// A redirect and a load-use stall come from different EX opcodes
	always_comb begin
		a_target_hold_excl: assert (!(flush && load_use))
			else $error("redirect_ctrl: redirect and stall in one cycle");
	end

endmodule

`default_nettype wire

// ==== rtl/rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 7;
	localparam int FUNCT3_W   = 3;
	localparam int FUNCT7_W   = 7;
	localparam int ALU_OP_W   = 4;
	localparam int MUL_OP_W   = 2;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;   // x0 is never a forwarding source
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [FUNCT3_W-1:0]   funct3_t;
	typedef logic [FUNCT7_W-1:0]   funct7_t;
	typedef logic [ALU_OP_W-1:0]   alu_op_t;
	typedef logic [MUL_OP_W-1:0]   mul_op_t;

	// RV32I major opcodes
	localparam opcode_t OP_RTYPE  = 7'b0110011;
	localparam opcode_t OP_ITYPE  = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;

	localparam alu_op_t ALU_PASS_LUI = 4'b1001;   // Pass immediate through the ALU

	// M-extension multiplier operations
	localparam mul_op_t MUL_MUL    = 2'b00;
	localparam mul_op_t MUL_MULH   = 2'b01;
	localparam mul_op_t MUL_MULHSU = 2'b10;
	localparam mul_op_t MUL_MULHU  = 2'b11;

	typedef enum logic [1:0] {
		FWD_REG,   // Register file value
		FWD_EX,    // One stage ahead
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	typedef enum logic [1:0] {RES_ALU, RES_MUL, RES_LINK} res_sel_t;

	typedef enum logic [1:0] {PC_NEXT, PC_TARGET, PC_HOLD} pc_sel_t;

	typedef enum logic [1:0] {INS_FETCH, INS_REPEAT, INS_NOP} instr_sel_t;

	typedef enum logic [2:0] {LD_NONE, LD_B, LD_H, LD_W, LD_HU, LD_BU} load_kind_t;

	typedef enum logic [1:0] {ST_NONE, ST_W, ST_H, ST_B} store_kind_t;

endpackage

`default_nettype wire

// ==== rtl/rv_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_top (
	input  logic                      clk,
	input  logic                      rst,
	input  rv_ctrl_pkg::xlen_t        instr,
	input  rv_ctrl_pkg::xlen_t        rs1_data,
	input  rv_ctrl_pkg::xlen_t        rs2_data,
	output rv_ctrl_pkg::alu_op_t      alu_op,
	output rv_ctrl_pkg::mul_op_t      mul_op,
	output rv_ctrl_pkg::res_sel_t     res_sel,
	output rv_ctrl_pkg::fwd_sel_t     fwd1_sel,
	output rv_ctrl_pkg::fwd_sel_t     fwd2_sel,
	output logic                      src1_pc,
	output logic                      src2_imm,
	output rv_ctrl_pkg::load_kind_t   load_kind,
	output rv_ctrl_pkg::store_kind_t  store_kind,
	output logic                      dm_web,
	output logic                      wb_en,
	output rv_ctrl_pkg::pc_sel_t      pc_sel,
	output rv_ctrl_pkg::instr_sel_t   instr_sel
);

	import rv_ctrl_pkg::*;

	opcode_t   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;

	reg_addr_t rd_ex;
	reg_addr_t rd_mem;
	reg_addr_t rd_wb;
	logic      wb_en_mem;
	logic      wb_en_wb;
	opcode_t   opcode_ex;
	logic      load_use;
	logic      load_use_q;
	logic      taken;
	logic      flush;

	// Standard RV32 field positions
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	dest_track u_dest_track (
		.clk(clk), .rst(rst), .opcode(opcode), .rd(rd), .load_use(load_use), .flush(flush),
		.wb_en(wb_en), .rd_ex(rd_ex), .rd_mem(rd_mem), .rd_wb(rd_wb),
		.wb_en_mem(wb_en_mem), .wb_en_wb(wb_en_wb)
	);

	op_decode u_op_decode (
		.clk(clk), .rst(rst), .opcode(opcode), .funct3(funct3), .funct7(funct7),
		.load_use(load_use), .alu_op(alu_op), .mul_op(mul_op), .res_sel(res_sel),
		.src1_pc(src1_pc), .src2_imm(src2_imm), .load_kind(load_kind),
		.store_kind(store_kind), .dm_web(dm_web)
	);

	hazard_ctrl u_hazard_ctrl (
		.clk(clk), .rst(rst), .opcode(opcode), .rs1(rs1), .rs2(rs2),
		.rd_ex(rd_ex), .rd_mem(rd_mem), .rd_wb(rd_wb),
		.wb_en(wb_en), .wb_en_mem(wb_en_mem), .wb_en_wb(wb_en_wb),
		.fwd1_sel(fwd1_sel), .fwd2_sel(fwd2_sel), .opcode_ex(opcode_ex),
		.load_use(load_use), .load_use_q(load_use_q)
	);

	branch_resolve u_branch_resolve (
		.clk(clk), .rst(rst), .opcode(opcode), .funct3(funct3),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .taken(taken)
	);

	redirect_ctrl u_redirect_ctrl (
		.opcode_ex(opcode_ex), .taken(taken), .load_use(load_use), .load_use_q(load_use_q),
		.pc_sel(pc_sel), .instr_sel(instr_sel), .flush(flush)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_ctrl -f sim.f -o vsim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vsim > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1

// ==== sim.f ====
rtl/rv_ctrl_pkg.sv
rtl/dest_track.sv
rtl/op_decode.sv
rtl/hazard_ctrl.sv
rtl/branch_resolve.sv
rtl/redirect_ctrl.sv
rtl/rv_ctrl_top.sv
bench/tb_rv_ctrl.sv
